/* Makefile */
SIM     = verilator
FLAGS   = --binary --timing --assert -Wno-fatal -j 0
TOP     = tb_dnc_write_interface
FLIST   = flist.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dnc_defines.svh */
// Width and size limit macros for the DNC write interface
`ifndef DNC_DEFINES_SVH
`define DNC_DEFINES_SVH

// Operand and accumulator widths
`define DNC_DATA_W 16
`define DNC_ACC_W 32

// Largest word size W and controller output size L
`define DNC_W_MAX 4
`define DNC_L_MAX 8

// One region holds a full W by L matrix
`define DNC_REGION_WORDS (`DNC_W_MAX * `DNC_L_MAX)

// Memory and size port widths
`define DNC_ADDR_W 8
`define DNC_SIZE_W 4

`endif

/* dnc_matrix_vector_engine.sv */
// Matrix-vector engine for write key, erase vector and write vector
// Row dot products against h, fetched word by word through the arbiter
`include "dnc_defines.svh"

module dnc_matrix_vector_engine (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  logic [`DNC_SIZE_W-1:0]   size_w,
  input  logic [`DNC_SIZE_W-1:0]   size_l,
  // Memory request
  output logic                     req,
  output logic [`DNC_ADDR_W-1:0]   addr,
  input  logic                     gnt,
  input  logic                     rvalid,
  input  logic [`DNC_DATA_W-1:0]   rd_data,
  // Row results
  output logic                     vec_out_enable,
  output dnc_pkg::result_kind_t    vec_kind,
  output logic [`DNC_SIZE_W-1:0]   vec_index,
  output logic [`DNC_ACC_W-1:0]    vec_data,
  output logic                     done
);

  import dnc_pkg::*;

  localparam int AW = `DNC_ADDR_W;
  localparam int ACC_W = `DNC_ACC_W;

  // Fetch FSM
  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_REQ_W = 3'd1;
  localparam logic [2:0] S_WAIT_W = 3'd2;
  localparam logic [2:0] S_REQ_H = 3'd3;
  localparam logic [2:0] S_WAIT_H = 3'd4;

  logic [2:0]                    st;
  result_kind_t                  kind;
  logic [`DNC_SIZE_W-1:0]        row;
  logic [`DNC_SIZE_W-1:0]        col;
  logic [`DNC_SIZE_W-1:0]        lat_w;
  logic [`DNC_SIZE_W-1:0]        lat_l;
  logic signed [`DNC_DATA_W-1:0] wgt;
  logic signed [ACC_W-1:0]       acc;
  logic signed [ACC_W-1:0]       prod;
  logic signed [ACC_W-1:0]       acc_next;
  logic [AW-1:0]                 w_addr;
  logic [AW-1:0]                 h_addr;
  logic                          h_hit;
  logic                          last_col;
  logic                          last_row;

  ////////////////////
  // Addressing
  ////////////////////

  // Row-major weights, h in its own region
  assign w_addr = AW'(kind) * AW'(`DNC_REGION_WORDS) + AW'(row) * AW'(`DNC_L_MAX) + AW'(col);
  assign h_addr = AW'(KIND_HIDDEN) * AW'(`DNC_REGION_WORDS) + AW'(col);

  assign req  = (st == S_REQ_W) || (st == S_REQ_H);
  assign addr = (st == S_REQ_H) ? h_addr : w_addr;

  ////////////////////
  // Multiply-accumulate
  ////////////////////

  // 16x16 signed product, accumulator wraps at 32 bits
  assign prod     = ACC_W'(wgt) * ACC_W'($signed(rd_data));
  assign acc_next = acc + prod;
  assign h_hit    = (st == S_WAIT_H) && rvalid;
  assign last_col = (col == lat_l - 1'b1);
  assign last_row = (row == lat_w - 1'b1);

  // Loop control
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      st             <= S_IDLE;
      kind           <= KIND_KEY;
      row            <= '0;
      col            <= '0;
      lat_w          <= '0;
      lat_l          <= '0;
      vec_out_enable <= 1'b0;
      done           <= 1'b0;
    end else begin
      vec_out_enable <= 1'b0;
      done           <= 1'b0;
      case (st)
        S_IDLE: begin
          if (start) begin
            lat_w <= size_w;
            lat_l <= size_l;
            kind  <= KIND_KEY;
            row   <= '0;
            col   <= '0;
            st    <= S_REQ_W;
          end
        end
        S_REQ_W: if (gnt) st <= S_WAIT_W;
        S_WAIT_W: if (rvalid) st <= S_REQ_H;
        S_REQ_H: if (gnt) st <= S_WAIT_H;
        S_WAIT_H: begin
          if (rvalid) begin
            st  <= S_REQ_W;
            col <= col + 1'b1;
            if (last_col) begin
              // Row finished
              vec_out_enable <= 1'b1;
              col            <= '0;
              row            <= row + 1'b1;
              if (last_row) begin
                row  <= '0;
                kind <= result_kind_t'(kind + 3'd1);
                if (kind == KIND_WVEC) begin
                  st   <= S_IDLE;
                  done <= 1'b1;
                end
              end
            end
          end
        end
        default: st <= S_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if ((st == S_IDLE) && start) begin
      acc <= '0;
    end else if (h_hit) begin
      acc <= last_col ? '0 : acc_next;
    end
    if ((st == S_WAIT_W) && rvalid) begin
      wgt <= $signed(rd_data);
    end
    if (h_hit && last_col) begin
      vec_kind  <= kind;
      vec_index <= row;
      vec_data  <= acc_next;
    end
  end

  // Controller only starts an idle engine
  a_start_idle: assert property (@(posedge CLK) disable iff (RST) start |-> st == S_IDLE);

endmodule

/* dnc_pkg.sv */
// Result kinds and controller states shared by the write interface
package dnc_pkg;

  ////////////////////
  // Result kinds
  ////////////////////

  // Same code picks the memory region and tags the output strobe
  typedef enum logic [2:0] {
    KIND_KEY    = 3'd0,
    KIND_ERASE  = 3'd1,
    KIND_WVEC   = 3'd2,
    KIND_BETA   = 3'd3,
    KIND_ALLOC  = 3'd4,
    KIND_WGATE  = 3'd5,
    // Region only, never emitted
    KIND_HIDDEN = 3'd6
  } result_kind_t;

  ////////////////////
  // Controller FSM
  ////////////////////

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_RUN    = 2'd1,
    // Single READY cycle
    ST_FINISH = 2'd2
  } ctrl_state_t;

endpackage

/* dnc_scalar_engine.sv */
// Scalar engine for write strength, allocation gate and write gate
`include "dnc_defines.svh"

module dnc_scalar_engine (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   start,
  input  logic [`DNC_SIZE_W-1:0] size_l,
  // Memory request
  output logic                   req,
  output logic [`DNC_ADDR_W-1:0] addr,
  input  logic                   gnt,
  input  logic                   rvalid,
  input  logic [`DNC_DATA_W-1:0] rd_data,
  // Scalar results
  output logic                   scal_out_enable,
  output dnc_pkg::result_kind_t  scal_kind,
  output logic [`DNC_ACC_W-1:0]  scal_data,
  output logic                   done
);

  import dnc_pkg::*;

  localparam int AW = `DNC_ADDR_W;
  localparam int ACC_W = `DNC_ACC_W;

  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_REQ_W = 3'd1;
  localparam logic [2:0] S_WAIT_W = 3'd2;
  localparam logic [2:0] S_REQ_H = 3'd3;
  localparam logic [2:0] S_WAIT_H = 3'd4;

  logic [2:0]                    st;
  result_kind_t                  kind;
  logic [`DNC_SIZE_W-1:0]        col;
  logic [`DNC_SIZE_W-1:0]        lat_l;
  logic signed [`DNC_DATA_W-1:0] wgt;
  logic signed [ACC_W-1:0]       acc;
  logic signed [ACC_W-1:0]       acc_next;
  logic                          h_hit;
  logic                          last_col;

  // One weight row per scalar, then the matching h element
  assign req  = (st == S_REQ_W) || (st == S_REQ_H);
  assign addr = (st == S_REQ_H) ? AW'(KIND_HIDDEN) * AW'(`DNC_REGION_WORDS) + AW'(col)
                                : AW'(kind) * AW'(`DNC_REGION_WORDS) + AW'(col);

  assign acc_next = acc + ACC_W'(wgt) * ACC_W'($signed(rd_data));
  assign h_hit    = (st == S_WAIT_H) && rvalid;
  assign last_col = (col == lat_l - 1'b1);

  ////////////////////
  // Loop control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      st              <= S_IDLE;
      kind            <= KIND_BETA;
      col             <= '0;
      lat_l           <= '0;
      scal_out_enable <= 1'b0;
      done            <= 1'b0;
    end else begin
      scal_out_enable <= 1'b0;
      done            <= 1'b0;
      case (st)
        S_IDLE: begin
          if (start) begin
            lat_l <= size_l;
            kind  <= KIND_BETA;
            col   <= '0;
            st    <= S_REQ_W;
          end
        end
        S_REQ_W: if (gnt) st <= S_WAIT_W;
        S_WAIT_W: if (rvalid) st <= S_REQ_H;
        S_REQ_H: if (gnt) st <= S_WAIT_H;
        S_WAIT_H: begin
          if (rvalid) begin
            st  <= S_REQ_W;
            col <= last_col ? '0 : col + 1'b1;
            if (last_col) begin
              scal_out_enable <= 1'b1;
              kind            <= result_kind_t'(kind + 3'd1);
              // Write gate is the last scalar
              if (kind == KIND_WGATE) begin
                st   <= S_IDLE;
                done <= 1'b1;
              end
            end
          end
        end
        default: st <= S_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if ((st == S_IDLE) && start) begin
      acc <= '0;
    end else if (h_hit) begin
      acc <= last_col ? '0 : acc_next;
    end
    if ((st == S_WAIT_W) && rvalid) wgt <= $signed(rd_data);
    if (h_hit && last_col) begin
      scal_kind <= kind;
      scal_data <= acc_next;
    end
  end

  // Data only arrives for a fetch this engine issued
  a_rvalid_owned: assert property (
    @(posedge CLK) disable iff (RST) rvalid |-> (st == S_WAIT_W) || (st == S_WAIT_H)
  );

endmodule

/* dnc_weight_arbiter.sv */
// Round-robin arbiter for the shared weight memory
// Two requesters, the matrix-vector engine (m) and the scalar engine (s)
`include "dnc_defines.svh"

module dnc_weight_arbiter (
  input  logic                   CLK,
  input  logic                   RST,
  // Matrix-vector engine
  input  logic                   m_req,
  input  logic [`DNC_ADDR_W-1:0] m_addr,
  output logic                   m_gnt,
  output logic                   m_rvalid,
  // Scalar engine
  input  logic                   s_req,
  input  logic [`DNC_ADDR_W-1:0] s_addr,
  output logic                   s_gnt,
  output logic                   s_rvalid,
  // Memory read port
  output logic                   rd_en,
  output logic [`DNC_ADDR_W-1:0] rd_addr
);

  // Set when s won the last grant
  logic last_s;

  ////////////////////
  // Grant
  ////////////////////

  // Lone requester goes straight through, a tie goes to the other side
  always_comb begin
    m_gnt = 1'b0;
    s_gnt = 1'b0;
    if (m_req && s_req) begin
      m_gnt = last_s;
      s_gnt = !last_s;
    end else begin
      m_gnt = m_req;
      s_gnt = s_req;
    end
  end

  assign rd_en   = m_gnt | s_gnt;
  assign rd_addr = s_gnt ? s_addr : m_addr;

  ////////////////////
  // Priority and return path
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      last_s   <= 1'b0;
      m_rvalid <= 1'b0;
      s_rvalid <= 1'b0;
    end else begin
      if (m_gnt) begin
        last_s <= 1'b0;
      end else if (s_gnt) begin
        last_s <= 1'b1;
      end
      // Read data lands one cycle after the grant
      m_rvalid <= m_gnt;
      s_rvalid <= s_gnt;
    end
  end

  // A waiting engine keeps its request and address until granted
  a_m_hold: assert property (
    @(posedge CLK) disable iff (RST) (m_req && !m_gnt) |=> (m_req && $stable(m_addr))
  );
  a_s_hold: assert property (
    @(posedge CLK) disable iff (RST) (s_req && !s_gnt) |=> (s_req && $stable(s_addr))
  );

endmodule

/* dnc_weight_memory.sv */
// Single-port weight and hidden-state RAM
// Host load port plus one registered read port
`include "dnc_defines.svh"

module dnc_weight_memory (
  input  logic                   CLK,
  input  logic                   RST,
  // Host load
  input  logic                   load_en,
  input  logic [`DNC_ADDR_W-1:0] load_addr,
  input  logic [`DNC_DATA_W-1:0] load_data,
  // Read from arbiter
  input  logic                   rd_en,
  input  logic [`DNC_ADDR_W-1:0] rd_addr,
  output logic [`DNC_DATA_W-1:0] rd_data
);

  localparam int DEPTH = 2 ** `DNC_ADDR_W;

  ////////////////////
  // Storage
  ////////////////////

  // All regions: key, erase, write vector, three scalar rows, h
  logic [`DNC_DATA_W-1:0] mem [0:DEPTH-1];

  // Single port, load wins over read
  always_ff @(posedge CLK) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (rd_en) begin
      // Word valid one cycle after the grant
      rd_data <= mem[rd_addr];
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Host must stay off the port while engines are fetching
  a_no_load_during_read: assert property (
    @(posedge CLK) disable iff (RST) !(load_en && rd_en)
  );

endmodule

/* dnc_write_interface_top.sv */
// Top level of the DNC write interface
// Controller, two engines, arbiter and shared weight memory
`include "dnc_defines.svh"

module dnc_write_interface_top (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [`DNC_SIZE_W-1:0] size_w,
  input  logic [`DNC_SIZE_W-1:0] size_l,
  // Host load
  input  logic                   load_en,
  input  logic [`DNC_ADDR_W-1:0] load_addr,
  input  logic [`DNC_DATA_W-1:0] load_data,
  output logic                   busy,
  output logic                   READY,
  // Vector results
  output logic                   vec_out_enable,
  output dnc_pkg::result_kind_t  vec_kind,
  output logic [`DNC_SIZE_W-1:0] vec_index,
  output logic [`DNC_ACC_W-1:0]  vec_data,
  // Scalar results
  output logic                   scal_out_enable,
  output dnc_pkg::result_kind_t  scal_kind,
  output logic [`DNC_ACC_W-1:0]  scal_data
);

  logic                   mv_start, sc_start, mv_done, sc_done;
  logic                   m_req, m_gnt, m_rvalid, s_req, s_gnt, s_rvalid;
  logic [`DNC_ADDR_W-1:0] m_addr, s_addr, rd_addr;
  logic                   rd_en;
  logic [`DNC_DATA_W-1:0] rd_data;

  dnc_write_interface_vector u_ctrl (
    .CLK(CLK), .RST(RST), .START(START), .size_w(size_w), .size_l(size_l),
    .mv_done(mv_done), .sc_done(sc_done), .mv_start(mv_start), .sc_start(sc_start),
    .busy(busy), .READY(READY)
  );

  dnc_matrix_vector_engine u_mv (
    .CLK(CLK), .RST(RST), .start(mv_start), .size_w(size_w), .size_l(size_l),
    .req(m_req), .addr(m_addr), .gnt(m_gnt), .rvalid(m_rvalid), .rd_data(rd_data),
    .vec_out_enable(vec_out_enable), .vec_kind(vec_kind), .vec_index(vec_index),
    .vec_data(vec_data), .done(mv_done)
  );

  dnc_scalar_engine u_sc (
    .CLK(CLK), .RST(RST), .start(sc_start), .size_l(size_l),
    .req(s_req), .addr(s_addr), .gnt(s_gnt), .rvalid(s_rvalid), .rd_data(rd_data),
    .scal_out_enable(scal_out_enable), .scal_kind(scal_kind), .scal_data(scal_data),
    .done(sc_done)
  );

  // Both engines read one port in turns
  dnc_weight_arbiter u_arb (
    .CLK(CLK), .RST(RST),
    .m_req(m_req), .m_addr(m_addr), .m_gnt(m_gnt), .m_rvalid(m_rvalid),
    .s_req(s_req), .s_addr(s_addr), .s_gnt(s_gnt), .s_rvalid(s_rvalid),
    .rd_en(rd_en), .rd_addr(rd_addr)
  );

  dnc_weight_memory u_mem (
    .CLK(CLK), .RST(RST), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
  );

  // Host loads only between runs
  a_load_idle: assert property (@(posedge CLK) disable iff (RST) load_en |-> !busy);

endmodule

/* dnc_write_interface_vector.sv */
// Write interface controller
// Starts both engines together and raises READY once both are done
`include "dnc_defines.svh"

module dnc_write_interface_vector (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  input  logic [`DNC_SIZE_W-1:0] size_w,
  input  logic [`DNC_SIZE_W-1:0] size_l,
  // Engine handshake
  input  logic                   mv_done,
  input  logic                   sc_done,
  output logic                   mv_start,
  output logic                   sc_start,
  // Status
  output logic                   busy,
  output logic                   READY
);

  import dnc_pkg::*;

  ctrl_state_t st;
  logic        start_q;
  logic        mv_fin;
  logic        sc_fin;
  logic        all_done;
  logic        accept;

  ////////////////////
  // FSM
  ////////////////////

  // Done pulses may arrive in either order or together
  assign all_done = (mv_fin | mv_done) & (sc_fin | sc_done);
  // New run also allowed in the READY cycle
  assign accept   = START && (st != ST_RUN);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      st      <= ST_IDLE;
      start_q <= 1'b0;
      mv_fin  <= 1'b0;
      sc_fin  <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (st)
        ST_IDLE, ST_FINISH: begin
          st <= ST_IDLE;
          if (accept) begin
            st      <= ST_RUN;
            start_q <= 1'b1;
            mv_fin  <= 1'b0;
            sc_fin  <= 1'b0;
          end
        end
        ST_RUN: begin
          if (mv_done) mv_fin <= 1'b1;
          if (sc_done) sc_fin <= 1'b1;
          // READY the cycle after the later done
          if (all_done) st <= ST_FINISH;
        end
        default: st <= ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Both engines share the one start pulse
  assign mv_start = start_q;
  assign sc_start = start_q;

  // busy drops in the READY cycle
  assign busy  = (st == ST_RUN);
  assign READY = (st == ST_FINISH);

  // Sizes must be in range when a run is accepted
  property p_size_ok;
    @(posedge CLK) disable iff (RST)
      accept |-> (size_w != 0) && (size_w <= `DNC_W_MAX) &&
                 (size_l != 0) && (size_l <= `DNC_L_MAX);
  endproperty
  a_size_ok: assert property (p_size_ok);

endmodule

/* flist.f */
+incdir+.
dnc_pkg.sv
dnc_weight_memory.sv
dnc_weight_arbiter.sv
dnc_matrix_vector_engine.sv
dnc_scalar_engine.sv
dnc_write_interface_vector.sv
dnc_write_interface_top.sv
tb_dnc_write_interface.sv

/* tb_dnc_write_interface.sv */
// Directed testbench for the DNC write interface
// Memory image, reference dot products, strobe monitors and six test tasks
`include "dnc_defines.svh"

module tb_dnc_write_interface;
  timeunit 1ns;
  timeprecision 1ps;

  import dnc_pkg::*;

  localparam int SW = `DNC_SIZE_W;
  localparam int AW = `DNC_ADDR_W;
  localparam int REGION = `DNC_REGION_WORDS;
  localparam int H_BASE = 6 * `DNC_REGION_WORDS;
  localparam int LAST_WORD = 7 * `DNC_REGION_WORDS - 1;
  // Worst run is about 240 reads at up to 3 cycles each, so roughly 750 cycles
  // Six runs plus five full loads and one h reload of 32 words stay under 6000
  localparam int TIMEOUT_CYCLES = 20000;

  logic CLK = 1'b0;
  logic RST;
  logic START;
  logic [SW-1:0] size_w;
  logic [SW-1:0] size_l;
  logic load_en;
  logic [AW-1:0] load_addr;
  logic [`DNC_DATA_W-1:0] load_data;
  logic busy;
  logic READY;
  logic vec_out_enable;
  result_kind_t vec_kind;
  logic [SW-1:0] vec_index;
  logic [`DNC_ACC_W-1:0] vec_data;
  logic scal_out_enable;
  result_kind_t scal_kind;
  logic [`DNC_ACC_W-1:0] scal_data;

  // Host copy of the weight memory
  logic signed [`DNC_DATA_W-1:0] img [0:255];

  // Captured results
  logic [31:0] vec_got [0:2][0:3];
  logic [31:0] scal_got [0:2];
  int vec_cnt [0:2];
  int scal_cnt;
  int vec_pos;
  int stray;
  int last_strobe;
  int ready_cycle;
  int cur_w = 1;
  int cycles = 0;
  int checks = 0;
  int value_errors = 0;
  int other_errors = 0;
  bit idle_watch = 1'b0;
  integer seed = 32'h1204;
  string cur_test = "init";

  dnc_write_interface_top dut0 (
    .CLK(CLK), .RST(RST), .START(START), .size_w(size_w), .size_l(size_l),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .busy(busy), .READY(READY),
    .vec_out_enable(vec_out_enable), .vec_kind(vec_kind), .vec_index(vec_index),
    .vec_data(vec_data), .scal_out_enable(scal_out_enable), .scal_kind(scal_kind),
    .scal_data(scal_data)
  );

  always #5 CLK = ~CLK;

  ////////////////////
  // Timeout
  ////////////////////

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in %s, the run hung", cycles, cur_test);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic compare_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[FAIL] %s: expected %0d, actual %0d", what, $signed(exp), $signed(act));
      value_errors++;
    end
  endtask

  task automatic require(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("[FAIL] %s: %s", cur_test, msg);
      other_errors++;
    end
  endtask

  // Wrapping 32-bit dot product of one weight row with h
  function automatic logic [31:0] ref_dot(input int row_base, input int len);
    logic signed [31:0] acc;
    logic signed [31:0] a;
    logic signed [31:0] b;
    acc = '0;
    for (int j = 0; j < len; j++) begin
      a = img[row_base + j];
      b = img[H_BASE + j];
      acc = acc + a * b;
    end
    return acc;
  endfunction

  ////////////////////
  // Monitors
  ////////////////////

  // Sampled away from the driving edge
  always @(negedge CLK) begin
    int k;
    int i;
    k = int'(vec_kind);
    i = int'(vec_index);
    if (!RST && vec_out_enable) begin
      require((k == vec_pos / cur_w) && (i == vec_pos % cur_w), "vector strobe out of order");
      if (k < 3 && i < `DNC_W_MAX) vec_got[k][i] = vec_data;
      if (k < 3) vec_cnt[k]++;
      if (i >= cur_w) stray++;
      vec_pos++;
      last_strobe = cycles;
    end
    if (!RST && scal_out_enable) begin
      k = int'(scal_kind) - 3;
      require(k == scal_cnt, "scalar strobe out of order");
      if (k >= 0 && k < 3) scal_got[k] = scal_data;
      scal_cnt++;
      last_strobe = cycles;
    end
    if (idle_watch) require(busy === 1'b0, "busy rose between READY and the next START");
  end

  ////////////////////
  // Drivers
  ////////////////////

  task automatic load_words(input int lo, input int hi);
    for (int a = lo; a <= hi; a++) begin
      @(posedge CLK);
      load_en <= 1'b1;
      load_addr <= AW'(a);
      load_data <= img[a];
    end
    @(posedge CLK);
    load_en <= 1'b0;
  endtask

  // Pulse START, then wait for READY under the global timeout
  task automatic run_once(input int w, input int l);
    for (int k = 0; k < 3; k++) begin
      vec_cnt[k] = 0;
      scal_got[k] = '0;
      for (int i = 0; i < 4; i++) vec_got[k][i] = '0;
    end
    scal_cnt = 0;
    vec_pos = 0;
    stray = 0;
    last_strobe = 0;
    cur_w = w;
    @(posedge CLK);
    size_w <= SW'(w);
    size_l <= SW'(l);
    START <= 1'b1;
    @(posedge CLK);
    START <= 1'b0;
    @(negedge CLK);
    require(busy === 1'b1, "busy did not rise after START");
    while (READY !== 1'b1) @(negedge CLK);
    ready_cycle = cycles;
    require(busy === 1'b0, "busy still high in the READY cycle");
  endtask

  // Compare every captured result and the strobe counts with the model
  task automatic check_results(input int w, input int l);
    result_kind_t kt;
    for (int k = 0; k < 3; k++) begin
      kt = result_kind_t'(k);
      compare_word($sformatf("%s %s count", cur_test, kt.name()), w, vec_cnt[k]);
      for (int i = 0; i < w; i++) begin
        compare_word($sformatf("%s %s[%0d]", cur_test, kt.name(), i),
                     ref_dot(k * REGION + i * `DNC_L_MAX, l), vec_got[k][i]);
      end
      kt = result_kind_t'(k + 3);
      compare_word($sformatf("%s %s", cur_test, kt.name()),
                   ref_dot((k + 3) * REGION, l), scal_got[k]);
    end
    compare_word({cur_test, " scalar count"}, 3, scal_cnt);
    compare_word({cur_test, " stray indices"}, 0, stray);
    require(ready_cycle > last_strobe, "READY came before the last result strobe");
  endtask

  task automatic fill_random(input int lo, input int hi);
    for (int a = lo; a <= hi; a++) img[a] = 16'($random(seed));
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    cur_test = "reset";
    repeat (8) begin
      @(negedge CLK);
      require(!READY && !busy && !vec_out_enable && !scal_out_enable,
              "output active after reset and before START");
    end
  endtask

  task automatic test_known_values();
    cur_test = "known_values";
    // Unit weights, h = j+1, spare h words tied to their address
    for (int a = 0; a <= LAST_WORD; a++) begin
      img[a] = (a < H_BASE) ? 16'sd1 : 16'(a);
    end
    for (int j = 0; j < `DNC_L_MAX; j++) img[H_BASE + j] = 16'(j + 1);
    load_words(0, LAST_WORD);
    run_once(4, 8);
    check_results(4, 8);
    // 1 + 2 + ... + 8
    for (int k = 0; k < 3; k++) begin
      compare_word($sformatf("%s scalar %0d fixed", cur_test, k), 32'd36, scal_got[k]);
      for (int i = 0; i < 4; i++) begin
        compare_word($sformatf("%s vec %0d[%0d] fixed", cur_test, k, i), 32'd36, vec_got[k][i]);
      end
    end
  endtask

  task automatic test_random_full();
    cur_test = "random_full";
    fill_random(0, LAST_WORD);
    load_words(0, LAST_WORD);
    run_once(4, 8);
    check_results(4, 8);
  endtask

  task automatic test_reduced_sizes();
    cur_test = "reduced_sizes";
    // Words past L and rows past W keep random data
    fill_random(0, LAST_WORD);
    load_words(0, LAST_WORD);
    run_once(2, 3);
    check_results(2, 3);
  endtask

  task automatic test_wrapping();
    logic signed [15:0] pick [0:3];
    cur_test = "wrapping";
    pick[0] = -16'sd32768;
    pick[1] = -16'sd32767;
    pick[2] = 16'sd32767;
    pick[3] = -16'sd1;
    for (int a = 0; a <= LAST_WORD; a++) img[a] = pick[$random(seed) & 3];
    // Key row 0 and h all at the minimum so eight products of 2^30 wrap to zero
    for (int j = 0; j < `DNC_L_MAX; j++) begin
      img[j] = -16'sd32768;
      img[H_BASE + j] = -16'sd32768;
    end
    load_words(0, LAST_WORD);
    run_once(4, 8);
    check_results(4, 8);
    compare_word({cur_test, " key[0] wrapped"}, 32'd0, vec_got[0][0]);
  endtask

  task automatic test_back_to_back();
    cur_test = "back_to_back";
    fill_random(0, LAST_WORD);
    load_words(0, LAST_WORD);
    run_once(4, 8);
    check_results(4, 8);
    // Only h changes for the second run
    idle_watch = 1'b1;
    fill_random(H_BASE, LAST_WORD);
    load_words(H_BASE, LAST_WORD);
    repeat (3) @(posedge CLK);
    idle_watch = 1'b0;
    cur_test = "back_to_back_second";
    run_once(4, 8);
    check_results(4, 8);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    RST = 1'b1;
    START = 1'b0;
    size_w = '0;
    size_l = '0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;
    test_reset();
    test_known_values();
    test_random_full();
    test_reduced_sizes();
    test_wrapping();
    test_back_to_back();
    repeat (2) @(posedge CLK);
    $display("Checks: %0d, value mismatches: %0d, other failures: %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
